// File: hw/aexmPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AEXM core package: widths, instruction field map, opcode and FSM encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package aexmPkg;

  // Datapath
  localparam int DataW    = 32;             // Data and address width
  localparam int RegAddrW = 5;              // Register index width
  localparam int NumRegs  = 1 << RegAddrW;
  localparam int ImmW     = 16;             // Raw immediate width
  localparam int PcStep   = 4;              // Byte step between words

  // First fetch address after reset
  localparam logic [DataW-1:0] ResetPc = '0;

  // Instruction field positions
  localparam int OpcMsb = 31;
  localparam int OpcLsb = 26;
  localparam int RdLsb  = 21;               // rd in 25:21
  localparam int RaLsb  = 16;               // ra in 20:16
  localparam int RbLsb  = 11;               // rb in 15:11, imm in 15:0

  // Supported opcodes, anything else decodes as NOP
  typedef enum logic [5:0] {
    OpAdd  = 6'b000000,  // rD = rA + rB
    OpRsub = 6'b000001,  // rD = rB - rA
    OpAddi = 6'b001000,  // rD = rA + simm
    OpOr   = 6'b100000,
    OpAnd  = 6'b100001,
    OpXor  = 6'b100010,
    OpBri  = 6'b101110,  // Always taken
    OpBeqi = 6'b101111,  // Taken when rA is zero
    OpLwi  = 6'b111010,
    OpSwi  = 6'b111110
  } aexmOpE;

  // Control FSM
  typedef enum logic [1:0] {
    StRun,               // Normal execution
    StFlush,             // Bubble behind a taken branch
    StLoadWait           // Load data written back
  } aexmStateE;

endpackage

// File: hw/aexmDecIf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded instruction bundle from the instruction buffer to the core blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface aexmDecIf;

  aexmPkg::aexmOpE               opcode;
  logic [aexmPkg::RegAddrW-1:0]  rd;      // Destination, or store source
  logic [aexmPkg::RegAddrW-1:0]  ra;
  logic [aexmPkg::RegAddrW-1:0]  rb;
  logic [aexmPkg::DataW-1:0]     simm;    // Sign-extended immediate
  logic                          valid;   // Low for bubbles

  // Decoder side
  modport dec (
    output opcode, rd, ra, rb, simm, valid
  );

  // Consumers: control, PC unit, register file, execute unit
  modport user (
    input opcode, rd, ra, rb, simm, valid
  );

endinterface

// File: hw/aexmIbuf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction buffer: latches the fetched word and splits it into fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module aexmIbuf (
  input  logic                      gclk,
  input  logic                      grst,
  input  logic [aexmPkg::DataW-1:0] iData_i,
  input  logic                      exEn_i,
  input  logic                      flush_i,
  aexmDecIf.dec                     dec
);

  logic [aexmPkg::DataW-1:0] insnQ;   // Word in decode
  logic                      vldQ;

  // Payload, follows the fetch stream
  always_ff @(posedge gclk) begin
    if (exEn_i) begin
      insnQ <= iData_i;
    end
  end

  // Squashed or pre-start words enter as bubbles
  always_ff @(posedge gclk) begin
    if (!grst) begin
      vldQ <= 1'b0;
    end else if (exEn_i) begin
      vldQ <= !flush_i;
    end
  end

  // Field split
  assign dec.opcode = aexmPkg::aexmOpE'(insnQ[aexmPkg::OpcMsb:aexmPkg::OpcLsb]);
  assign dec.rd     = insnQ[aexmPkg::RdLsb +: aexmPkg::RegAddrW];
  assign dec.ra     = insnQ[aexmPkg::RaLsb +: aexmPkg::RegAddrW];
  assign dec.rb     = insnQ[aexmPkg::RbLsb +: aexmPkg::RegAddrW];
  assign dec.valid  = vldQ;

  // Sign extension of imm16
  assign dec.simm = {{(aexmPkg::DataW - aexmPkg::ImmW){insnQ[aexmPkg::ImmW-1]}},
                     insnQ[aexmPkg::ImmW-1:0]};

endmodule

// File: hw/aexmCtrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline control FSM for busy_n stalls, branch flush and load wait
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module aexmCtrl (
  input  logic   gclk,
  input  logic   grst,
  input  logic   iBusyN_i,
  input  logic   dBusyN_i,
  input  logic   branchTaken_i,
  aexmDecIf.user dec,
  output logic   exEn_o,
  output logic   flush_o,
  output logic   loadWb_o,
  output logic   iEn_o,
  output logic   dEn_o,
  output logic   dWe_o
);

  aexmPkg::aexmStateE state;
  aexmPkg::aexmStateE stateNxt;
  logic runQ;                  // Fetching has started
  logic primedQ;               // iData_i carries a real fetched word
  logic busOk;
  logic taken;
  logic isLoad;
  logic isStore;
  logic inRun;

  assign busOk   = iBusyN_i & dBusyN_i;
  assign inRun   = (state == aexmPkg::StRun);
  assign taken   = branchTaken_i & dec.valid;
  assign isLoad  = dec.valid & (dec.opcode == aexmPkg::OpLwi);
  assign isStore = dec.valid & (dec.opcode == aexmPkg::OpSwi);

  // Fetch held in load wait
  // A data stall must not let the I side overwrite the word waiting for decode
  assign iEn_o    = runQ & dBusyN_i & (state != aexmPkg::StLoadWait);
  assign exEn_o   = busOk & iEn_o;
  assign flush_o  = !primedQ | taken;      // Drop the word behind a taken branch
  assign loadWb_o = busOk & (state == aexmPkg::StLoadWait);

  // Store must not repeat while the fetch side stalls
  assign dEn_o = iBusyN_i & inRun & (isLoad | isStore);
  assign dWe_o = iBusyN_i & inRun & isStore;

  always_comb begin
    stateNxt = state;
    case (state)
      aexmPkg::StRun: begin
        if (taken) begin
          stateNxt = aexmPkg::StFlush;
        end else if (isLoad) begin
          stateNxt = aexmPkg::StLoadWait;
        end
      end
      default: stateNxt = aexmPkg::StRun;   // Both extra states last one cycle
    endcase
  end

  always_ff @(posedge gclk) begin
    if (!grst) begin
      state   <= aexmPkg::StRun;
      runQ    <= 1'b0;
      primedQ <= 1'b0;
    end else if (busOk) begin
      state <= stateNxt;
      runQ  <= 1'b1;
      if (exEn_o) primedQ <= 1'b1;        // First fetch has been sampled
    end
  end

endmodule

// File: hw/aexmPcUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program counter: fetch counter with branch load, tracks PC of decode slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module aexmPcUnit (
  input  logic                      gclk,
  input  logic                      grst,
  input  logic                      exEn_i,
  input  logic                      loadWb_i,
  input  logic                      branchTaken_i,
  input  logic [aexmPkg::DataW-1:0] branchTarget_i,
  aexmDecIf.user                    dec,
  output logic [aexmPkg::DataW-1:0] iAddr_o,
  output logic [aexmPkg::DataW-1:0] pcDec_o
);

  logic [aexmPkg::DataW-1:0] pcFetchQ;   // Next sequential fetch
  logic [aexmPkg::DataW-1:0] pcIssQ;     // Address now on iData_i
  logic [aexmPkg::DataW-1:0] pcDecQ;     // Address of decode slot
  logic                      redirect;
  logic                      advance;

  // Target goes out in the branch's own cycle, one word lost
  assign redirect = branchTaken_i & dec.valid;
  assign iAddr_o  = redirect ? branchTarget_i : pcFetchQ;
  assign advance  = exEn_i & !loadWb_i;  // Frozen while load data lands

  always_ff @(posedge gclk) begin
    if (!grst) begin
      pcFetchQ <= aexmPkg::ResetPc;
    end else if (advance) begin
      pcFetchQ <= iAddr_o + aexmPkg::PcStep;
    end
  end

  // Follows the word through fetch and decode
  always_ff @(posedge gclk) begin
    if (advance) begin
      pcIssQ <= iAddr_o;
      pcDecQ <= pcIssQ;
    end
  end

  assign pcDec_o = pcDecQ;

endmodule

// File: hw/aexmRegFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file: 32 x 32, three read ports, one write port, r0 reads zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module aexmRegFile (
  input  logic                         gclk,
  input  logic                         grst,
  aexmDecIf.user                       dec,
  input  logic                         wbEn_i,
  input  logic [aexmPkg::RegAddrW-1:0] wbIdx_i,
  input  logic [aexmPkg::DataW-1:0]    wbData_i,
  input  logic                         loadWb_i,
  input  logic [aexmPkg::DataW-1:0]    dData_i,
  output logic [aexmPkg::DataW-1:0]    regA_o,
  output logic [aexmPkg::DataW-1:0]    regB_o,
  output logic [aexmPkg::DataW-1:0]    regD_o
);

  logic [aexmPkg::DataW-1:0]    regMem [aexmPkg::NumRegs];
  logic [aexmPkg::RegAddrW-1:0] ldIdxQ;    // rd of outstanding load
  logic                         ldPendQ;
  logic                         ldCapture;

  // Reads, r0 forced to zero
  assign regA_o = (dec.ra == '0) ? '0 : regMem[dec.ra];
  assign regB_o = (dec.rb == '0) ? '0 : regMem[dec.rb];
  assign regD_o = (dec.rd == '0) ? '0 : regMem[dec.rd];  // Store data

  // Latch rd once per load, the next word may be a load too
  assign ldCapture = dec.valid & (dec.opcode == aexmPkg::OpLwi) & !ldPendQ;

  always_ff @(posedge gclk) begin
    if (!grst) begin
      ldPendQ <= 1'b0;
    end else if (loadWb_i) begin
      ldPendQ <= 1'b0;
    end else if (ldCapture) begin
      ldPendQ <= 1'b1;
    end
  end

  always_ff @(posedge gclk) begin
    if (ldCapture) ldIdxQ <= dec.rd;
  end

  // Load data has priority, decode slot is idle then
  always_ff @(posedge gclk) begin
    if (loadWb_i) begin
      if (ldIdxQ != '0) regMem[ldIdxQ] <= dData_i;
    end else if (wbEn_i && (wbIdx_i != '0)) begin
      regMem[wbIdx_i] <= wbData_i;
    end
  end

endmodule

// File: hw/aexmExec.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute unit: ALU, branch condition and target, data address and store data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module aexmExec (
  aexmDecIf.user                        dec,
  input  logic                          exEn_i,
  input  logic [aexmPkg::DataW-1:0]     pcDec_i,
  input  logic [aexmPkg::DataW-1:0]     regA_i,
  input  logic [aexmPkg::DataW-1:0]     regB_i,
  input  logic [aexmPkg::DataW-1:0]     regD_i,
  output logic [aexmPkg::DataW-1:0]     result_o,
  output logic                          wbEn_o,
  output logic [aexmPkg::RegAddrW-1:0]  wbIdx_o,
  output logic                          branchTaken_o,
  output logic [aexmPkg::DataW-1:0]     branchTarget_o,
  output logic [aexmPkg::DataW-1:0]     dAddr_o,
  output logic [aexmPkg::DataW-1:0]     dData_o
);

  logic isAlu;

  // ALU
  always_comb begin
    isAlu    = 1'b1;
    result_o = '0;
    case (dec.opcode)
      aexmPkg::OpAdd:  result_o = regA_i + regB_i;
      aexmPkg::OpRsub: result_o = regB_i - regA_i;   // Reverse subtract
      aexmPkg::OpAddi: result_o = regA_i + dec.simm;
      aexmPkg::OpOr:   result_o = regA_i | regB_i;
      aexmPkg::OpAnd:  result_o = regA_i & regB_i;
      aexmPkg::OpXor:  result_o = regA_i ^ regB_i;
      default:         isAlu    = 1'b0;              // Branches, memory, NOPs
    endcase
  end

  assign wbEn_o  = dec.valid & isAlu & exEn_i;  // Loads write back via control
  assign wbIdx_o = dec.rd;

  // Condition only, the slot's valid is applied by the users
  always_comb begin
    case (dec.opcode)
      aexmPkg::OpBri:  branchTaken_o = 1'b1;
      aexmPkg::OpBeqi: branchTaken_o = (regA_i == '0);
      default:         branchTaken_o = 1'b0;
    endcase
  end

  // Byte offsets relative to the branch itself
  assign branchTarget_o = pcDec_i + dec.simm;

  // Memory side
  assign dAddr_o = regA_i + dec.simm;
  assign dData_o = regD_i;

endmodule

// File: hw/aexmCore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AEXM core top: fetch, decode and execute blocks on split I and D ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module aexmCore (
  input  logic                      gclk,
  input  logic                      grst,
  // Instruction port
  output logic [aexmPkg::DataW-1:0] iAddr_o,
  output logic                      iEn_o,
  input  logic [aexmPkg::DataW-1:0] iData_i,
  input  logic                      iBusyN_i,
  // Data port
  output logic [aexmPkg::DataW-1:0] dAddr_o,
  output logic [aexmPkg::DataW-1:0] dData_o,
  output logic                      dWe_o,
  output logic                      dEn_o,
  input  logic [aexmPkg::DataW-1:0] dData_i,
  input  logic                      dBusyN_i
);

  logic                         exEn;
  logic                         flush;
  logic                         loadWb;
  logic                         branchTaken;
  logic [aexmPkg::DataW-1:0]    branchTarget;
  logic [aexmPkg::DataW-1:0]    pcDec;
  logic [aexmPkg::DataW-1:0]    regA;
  logic [aexmPkg::DataW-1:0]    regB;
  logic [aexmPkg::DataW-1:0]    regD;
  logic [aexmPkg::DataW-1:0]    result;
  logic                         wbEn;
  logic [aexmPkg::RegAddrW-1:0] wbIdx;

  aexmDecIf decIf ();

  aexmIbuf i_aexmIbuf (
    .gclk    (gclk),
    .grst    (grst),
    .iData_i (iData_i),
    .exEn_i  (exEn),
    .flush_i (flush),
    .dec     (decIf.dec)
  );

  aexmCtrl i_aexmCtrl (
    .gclk          (gclk),
    .grst          (grst),
    .iBusyN_i      (iBusyN_i),
    .dBusyN_i      (dBusyN_i),
    .branchTaken_i (branchTaken),
    .dec           (decIf.user),
    .exEn_o        (exEn),
    .flush_o       (flush),
    .loadWb_o      (loadWb),
    .iEn_o         (iEn_o),
    .dEn_o         (dEn_o),
    .dWe_o         (dWe_o)
  );

  aexmPcUnit i_aexmPcUnit (
    .gclk           (gclk),
    .grst           (grst),
    .exEn_i         (exEn),
    .loadWb_i       (loadWb),
    .branchTaken_i  (branchTaken),
    .branchTarget_i (branchTarget),
    .dec            (decIf.user),
    .iAddr_o        (iAddr_o),
    .pcDec_o        (pcDec)
  );

  aexmRegFile i_aexmRegFile (
    .gclk     (gclk),
    .grst     (grst),
    .dec      (decIf.user),
    .wbEn_i   (wbEn),
    .wbIdx_i  (wbIdx),
    .wbData_i (result),
    .loadWb_i (loadWb),
    .dData_i  (dData_i),
    .regA_o   (regA),
    .regB_o   (regB),
    .regD_o   (regD)
  );

  aexmExec i_aexmExec (
    .dec            (decIf.user),
    .exEn_i         (exEn),
    .pcDec_i        (pcDec),
    .regA_i         (regA),
    .regB_i         (regB),
    .regD_i         (regD),
    .result_o       (result),
    .wbEn_o         (wbEn),
    .wbIdx_o        (wbIdx),
    .branchTaken_o  (branchTaken),
    .branchTarget_o (branchTarget),
    .dAddr_o        (dAddr_o),
    .dData_o        (dData_o)
  );

endmodule

// File: tests/tbRefModel.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference ISA model and test program for the AEXM core testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [31:0] progMem [64];   // Test program, word indexed
  int          progLen;
  logic [31:0] expAddr [$];    // Expected stores, program order
  logic [31:0] expData [$];

  // Register form: op rd ra rb
  function automatic logic [31:0] encR(logic [5:0] op, int rd, int ra, int rb);
    return {op, rd[4:0], ra[4:0], rb[4:0], 11'd0};
  endfunction

  // Immediate form, imm truncated to 16 bits
  function automatic logic [31:0] encI(logic [5:0] op, int rd, int ra, int imm);
    return {op, rd[4:0], ra[4:0], imm[15:0]};
  endfunction

  // Data RAM preset, mixes every bit of the word index
  function automatic logic [31:0] presetWord(int idx);
    return (idx * 32'h9e37_79b9) ^ 32'h5a00_00c3;
  endfunction

  task automatic addInsn(logic [31:0] w);
    progMem[progLen] = w;
    progLen++;
  endtask

  task automatic buildProgram();
    progLen = 0;
    addInsn(encI(aexmPkg::OpAddi, 1, 0, 100));
    addInsn(encI(aexmPkg::OpAddi, 2, 0, -7));      // Negative immediate
    addInsn(encR(aexmPkg::OpAdd, 3, 1, 2));
    addInsn(encI(aexmPkg::OpSwi, 3, 0, 'h80));
    addInsn(encR(aexmPkg::OpRsub, 4, 1, 2));       // r2 - r1
    addInsn(encI(aexmPkg::OpSwi, 4, 0, 'h84));
    addInsn(encR(aexmPkg::OpAnd, 5, 1, 2));
    addInsn(encR(aexmPkg::OpOr, 6, 1, 2));
    addInsn(encR(aexmPkg::OpXor, 7, 5, 6));
    addInsn(encI(aexmPkg::OpSwi, 7, 0, 'h88));
    addInsn(encR(aexmPkg::OpAdd, 0, 1, 1));        // Write to r0 is dropped
    addInsn(encI(aexmPkg::OpSwi, 0, 0, 'h8c));
    addInsn(encI(aexmPkg::OpLwi, 8, 0, 'h10));
    addInsn(encI(aexmPkg::OpAddi, 9, 8, -1));      // Load-use
    addInsn(encI(aexmPkg::OpSwi, 9, 0, 'h90));
    addInsn(encI(aexmPkg::OpLwi, 10, 1, -96));     // Base plus negative offset
    addInsn(encR(aexmPkg::OpXor, 11, 10, 8));
    addInsn(encI(aexmPkg::OpSwi, 11, 2, 'h9b));    // Lands on 0x94
    addInsn(encI(aexmPkg::OpBeqi, 0, 0, 12));      // Taken
    addInsn(encI(aexmPkg::OpSwi, 1, 0, 'ha0));     // Flushed word
    addInsn(encI(aexmPkg::OpSwi, 1, 0, 'ha4));     // Never fetched
    addInsn(encI(aexmPkg::OpBeqi, 0, 1, 8));       // Not taken, r1 nonzero
    addInsn(encI(aexmPkg::OpSwi, 5, 0, 'h98));
    addInsn(encI(aexmPkg::OpBri, 0, 0, 8));
    addInsn(encI(aexmPkg::OpSwi, 6, 0, 'ha8));     // Skipped by BRI
    addInsn(encI(aexmPkg::OpSwi, 6, 0, 'h9c));
    addInsn(encI(aexmPkg::OpAddi, 14, 0, 3));      // Countdown loop
    addInsn(encI(aexmPkg::OpAddi, 14, 14, -1));
    addInsn(encI(aexmPkg::OpSwi, 14, 0, 'hb0));
    addInsn(encI(aexmPkg::OpBeqi, 0, 14, 8));      // Loop exit
    addInsn(encI(aexmPkg::OpBri, 0, 0, -12));      // Backward branch
    addInsn(encI(aexmPkg::OpBri, 0, 0, 0));        // Halt, branch to self
  endtask

  // Runs the program on ISA rules and queues every store
  function automatic void refRun();
    logic [31:0] regs [32];
    logic [31:0] mem [64];
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] w;
    logic [31:0] simm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    logic [31:0] addr;
    logic [31:0] res;
    logic [4:0]  rd;
    logic        wr;
    logic        halted;
    int          i;
    int          steps;
    for (i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (i = 0; i < 64; i++) begin
      mem[i] = presetWord(i);
    end
    pc = aexmPkg::ResetPc;
    halted = 1'b0;
    steps = 0;
    while (!halted && steps < 1000) begin
      w      = progMem[pc[7:2]];
      rd     = w[25:21];
      a      = regs[w[20:16]];
      b      = regs[w[15:11]];
      d      = regs[rd];
      simm   = {{16{w[15]}}, w[15:0]};
      addr   = a + simm;
      nextPc = pc + 4;
      res    = '0;
      wr     = 1'b1;
      case (w[31:26])
        aexmPkg::OpAdd:  res = a + b;
        aexmPkg::OpRsub: res = b - a;
        aexmPkg::OpAddi: res = a + simm;
        aexmPkg::OpOr:   res = a | b;
        aexmPkg::OpAnd:  res = a & b;
        aexmPkg::OpXor:  res = a ^ b;
        aexmPkg::OpLwi:  res = mem[addr[7:2]];
        aexmPkg::OpSwi: begin
          mem[addr[7:2]] = d;
          expAddr.push_back(addr);
          expData.push_back(d);
          wr = 1'b0;
        end
        aexmPkg::OpBri: begin
          halted = (simm == '0);
          nextPc = pc + simm;                    // Offset from the branch itself
          wr = 1'b0;
        end
        aexmPkg::OpBeqi: begin
          if (a == '0) nextPc = pc + simm;
          wr = 1'b0;
        end
        default: wr = 1'b0;                      // NOP
      endcase
      if (wr && rd != '0) regs[rd] = res;        // r0 stays zero
      pc = nextPc;
      steps++;
    end
  endfunction

// File: tests/tbCore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AEXM core with memory models, random busy_n and stores
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tbCore;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod = 8;
  localparam int RstCycles = 5;

  logic        gclk = 1'b0;
  logic        grst = 1'b0;
  logic [31:0] iAddr;
  logic        iEn;
  logic [31:0] iData = '0;
  logic        iBusyN = 1'b1;
  logic [31:0] dAddr;
  logic [31:0] dDataOut;
  logic        dWe;
  logic        dEn;
  logic [31:0] dDataIn = '0;
  logic        dBusyN = 1'b1;

  logic [31:0] instrRom [64];
  logic [31:0] dataRam [64];
  integer      seed = 32'haa7c_605f;
  int          errCount = 0;
  int          storeCount = 0;
  int          expTotal = 0;
  int          cycleCnt = 0;
  logic        fetchSeen = 1'b0;   // First fetch address checked

  `include "tbRefModel.svh"

  initial begin
    forever #(ClkPeriod / 2) gclk = ~gclk;
  end

  aexmCore i_aexmCore (
    .gclk     (gclk),
    .grst     (grst),
    .iAddr_o  (iAddr),
    .iEn_o    (iEn),
    .iData_i  (iData),
    .iBusyN_i (iBusyN),
    .dAddr_o  (dAddr),
    .dData_o  (dDataOut),
    .dWe_o    (dWe),
    .dEn_o    (dEn),
    .dData_i  (dDataIn),
    .dBusyN_i (dBusyN)
  );

  // Random stalls about one cycle in four
  always @(posedge gclk) begin
    iBusyN   <= ($random(seed) & 3) != 0;
    dBusyN   <= ($random(seed) & 3) != 0;
    cycleCnt <= cycleCnt + 1;
  end

  // Instruction ROM answers one cycle after the sampled address
  always @(posedge gclk) begin
    if (iEn && iBusyN) iData <= instrRom[iAddr[7:2]];
  end

  // Data RAM follows the same sampling rule
  always @(posedge gclk) begin
    if (dEn && dBusyN) begin
      if (dWe) dataRam[dAddr[7:2]] <= dDataOut;
      else dDataIn <= dataRam[dAddr[7:2]];
    end
  end

  // Compares against the reference store queue
  always @(posedge gclk) begin
    if (!grst && cycleCnt > 0 && {iEn, dEn, dWe} !== 3'b000) begin
      $display("FAIL %0t {iEn_o,dEn_o,dWe_o} got %b expected 000", $time, {iEn, dEn, dWe});
      errCount++;
    end
    if (grst && iEn && iBusyN && !fetchSeen) begin
      fetchSeen <= 1'b1;
      if (iAddr !== aexmPkg::ResetPc) begin
        $display("FAIL %0t iAddr_o got %h expected %h", $time, iAddr, aexmPkg::ResetPc);
        errCount++;
      end
    end
    if (grst && dEn && dWe && dBusyN) begin
      storeCount++;
      if (expAddr.size() == 0) begin
        $display("Unexpected store to %h at %0t", dAddr, $time);
        errCount++;
      end else begin
        if (dAddr !== expAddr[0]) begin
          $display("FAIL %0t dAddr_o got %h expected %h", $time, dAddr, expAddr[0]);
          errCount++;
        end
        if (dDataOut !== expData[0]) begin
          $display("FAIL %0t dData_o got %h expected %h", $time, dDataOut, expData[0]);
          errCount++;
        end
        void'(expAddr.pop_front());
        void'(expData.pop_front());
      end
    end
  end

  task automatic reportAndFinish();
    $display("Errors: %0d, stores seen %0d of %0d expected", errCount, storeCount, expTotal);
    if (errCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  initial begin
    int i;
    buildProgram();
    refRun();
    expTotal = expAddr.size();
    for (i = 0; i < 64; i++) begin
      instrRom[i] = (i < progLen) ? progMem[i] : '0;   // Tail of zeros acts as NOP
      dataRam[i]  = presetWord(i);
    end
    repeat (RstCycles) @(posedge gclk);
    grst <= 1'b1;
    while (expAddr.size() != 0) @(posedge gclk);
    repeat (20) @(negedge gclk);                       // Catch stray stores
    reportAndFinish();
  end

  // Watchdog allows 40 cycles per instruction plus slack
  initial begin
    wait (progLen != 0);
    #((40 * progLen + 200) * ClkPeriod);
    $display("Timeout: %0d expected stores never arrived", expAddr.size());
    errCount++;
    reportAndFinish();
  end

endmodule

// File: all.f
+incdir+tests
hw/aexmPkg.sv
hw/aexmDecIf.sv
hw/aexmIbuf.sv
hw/aexmCtrl.sv
hw/aexmPcUnit.sv
hw/aexmRegFile.sv
hw/aexmExec.sv
hw/aexmCore.sv
tests/tbCore.sv

// File: Bender.yml
package:
  name: aexm_core

sources:
  - files:
      - hw/aexmPkg.sv
      - hw/aexmDecIf.sv
      - hw/aexmIbuf.sv
      - hw/aexmCtrl.sv
      - hw/aexmPcUnit.sv
      - hw/aexmRegFile.sv
      - hw/aexmExec.sv
      - hw/aexmCore.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tbCore.sv
